/* common/cp0_reg_pkg.sv */
package cp0_reg_pkg;

	typedef logic [31:0] cp0_word_t;	// one cp0 register word
	typedef logic [4:0]  cp0_addr_t;	// cp0 register number (rd field)

	// register numbers for select 0 only
	localparam cp0_addr_t CP0_BADVADDR = 5'd8;
	localparam cp0_addr_t CP0_COUNT    = 5'd9;
	localparam cp0_addr_t CP0_COMPARE  = 5'd11;
	localparam cp0_addr_t CP0_STATUS   = 5'd12;
	localparam cp0_addr_t CP0_CAUSE    = 5'd13;
	localparam cp0_addr_t CP0_EPC      = 5'd14;
	localparam cp0_addr_t CP0_PRID     = 5'd15;

	localparam int STATUS_IE       = 0;	// global interrupt enable
	localparam int STATUS_EXL      = 1;	// exception level
	localparam int STATUS_IM_SW_LO = 8;	// sw interrupt mask
	localparam int STATUS_IM_SW_HI = 9;
	localparam int STATUS_IM_LO    = 10;	// hw interrupt mask
	localparam int STATUS_IM_HI    = 15;

	localparam int CAUSE_BD       = 31;	// victim sat in a delay slot
	localparam int CAUSE_IP_SW_LO = 8;	// sw pending and writable
	localparam int CAUSE_IP_SW_HI = 9;
	localparam int CAUSE_IP_HW_LO = 10;	// hw pending recorded on trap
	localparam int CAUSE_IP_HW_HI = 15;
	localparam int CAUSE_CODE_LO  = 2;	// exccode field
	localparam int CAUSE_CODE_HI  = 6;
	localparam int CAUSE_WR_LO    = 22;	// IV and WP are sw writable
	localparam int CAUSE_WR_HI    = 23;

	localparam cp0_word_t STATUS_RESET = 32'h1000_0000;	// CU0 set and everything else off
	localparam cp0_word_t PRID_VALUE   = 32'h0057_0102;	// company 0x57 impl 0x01 rev 2

endpackage

/* common/cp0_exc_pkg.sv */
package cp0_exc_pkg;

	typedef logic [7:0] exc_vec_t;	// one-hot exception request from the pipe
	typedef logic [4:0] exc_code_t;	// value written to Cause.ExcCode
	typedef logic [5:0] hw_irq_t;	// {timer, int_i[4:0]}
	typedef logic [1:0] sw_irq_t;	// Cause.IP[1:0]

	// bit positions inside exc_vec_t
	localparam int EXV_BP   = 0;
	localparam int EXV_SYS  = 1;
	localparam int EXV_RI   = 2;
	localparam int EXV_OV   = 3;
	localparam int EXV_TR   = 4;
	localparam int EXV_ERET = 5;
	localparam int EXV_ADEL = 6;	// fetch or load misaligned
	localparam int EXV_ADES = 7;	// store misaligned

	localparam exc_code_t EXC_INT  = 5'd0;
	localparam exc_code_t EXC_ADEL = 5'd4;
	localparam exc_code_t EXC_ADES = 5'd5;
	localparam exc_code_t EXC_SYS  = 5'd8;
	localparam exc_code_t EXC_BP   = 5'd9;
	localparam exc_code_t EXC_RI   = 5'd10;
	localparam exc_code_t EXC_OV   = 5'd12;
	localparam exc_code_t EXC_TR   = 5'd13;
	localparam exc_code_t EXC_NONE = 5'd30;	// nothing to take
	localparam exc_code_t EXC_ERET = 5'd31;	// internal only for return from handler

	localparam logic [31:0] EXC_VECTOR        = 32'hbfc0_0380;	// general vector with BEV=1
	localparam logic [31:0] DELAY_SLOT_OFFSET = 32'd4;	// branch sits one word back

endpackage

/* exception/cp0_trap_arbiter.sv */
`timescale 1ns/100ps
module cp0_trap_arbiter (
	input  logic                   rst_n,
	input  logic                   wcp0,
	input  cp0_reg_pkg::cp0_addr_t waddr,
	input  cp0_reg_pkg::cp0_word_t wdata,
	input  cp0_exc_pkg::exc_vec_t  exc_type,
	input  logic [4:0]             int_i,
	input  logic                   timer_int,
	input  cp0_reg_pkg::cp0_word_t status,
	input  cp0_reg_pkg::cp0_word_t cause_reg,
	input  cp0_reg_pkg::cp0_word_t epc,
	output logic                   exc_en,
	output cp0_reg_pkg::cp0_word_t pc_exc,
	output logic                   trap_take,
	output cp0_exc_pkg::exc_code_t exc_code,
	output cp0_exc_pkg::hw_irq_t   hw_irq,
	output logic                   sw_write
);

	cp0_exc_pkg::sw_irq_t   sw_irq;
	cp0_reg_pkg::cp0_word_t epc_fwd;
	logic                   exl;
	logic                   int_take;

	assign exl = status[cp0_reg_pkg::STATUS_EXL];

	// masked pending lines are zero while EXL is set
	assign hw_irq = exl ? '0 : ({timer_int, int_i} &
		status[cp0_reg_pkg::STATUS_IM_HI:cp0_reg_pkg::STATUS_IM_LO]);
	assign sw_irq = exl ? '0 :
		(cause_reg[cp0_reg_pkg::CAUSE_IP_SW_HI:cp0_reg_pkg::CAUSE_IP_SW_LO] &
		status[cp0_reg_pkg::STATUS_IM_SW_HI:cp0_reg_pkg::STATUS_IM_SW_LO]);
	assign int_take = status[cp0_reg_pkg::STATUS_IE] & ((hw_irq != '0) | (sw_irq != '0));

	// fixed priority where interrupts lose to any synchronous exception
	always_comb
	begin
		if (exc_type[cp0_exc_pkg::EXV_ADEL])
			exc_code = cp0_exc_pkg::EXC_ADEL;
		else if (exc_type[cp0_exc_pkg::EXV_ADES])
			exc_code = cp0_exc_pkg::EXC_ADES;
		else if (exc_type[cp0_exc_pkg::EXV_SYS])
			exc_code = cp0_exc_pkg::EXC_SYS;
		else if (exc_type[cp0_exc_pkg::EXV_BP])
			exc_code = cp0_exc_pkg::EXC_BP;
		else if (exc_type[cp0_exc_pkg::EXV_RI])
			exc_code = cp0_exc_pkg::EXC_RI;
		else if (exc_type[cp0_exc_pkg::EXV_OV])
			exc_code = cp0_exc_pkg::EXC_OV;
		else if (exc_type[cp0_exc_pkg::EXV_TR])
			exc_code = cp0_exc_pkg::EXC_TR;
		else if (exc_type[cp0_exc_pkg::EXV_ERET])
			exc_code = cp0_exc_pkg::EXC_ERET;
		else if (int_take)
			exc_code = cp0_exc_pkg::EXC_INT;
		else
			exc_code = cp0_exc_pkg::EXC_NONE;
	end

	assign trap_take = (exc_type != '0) | int_take;
	assign sw_write  = wcp0 & ~trap_take;	// mtc0 squashed by a trap

	// mtc0 epc right before eret would otherwise return to the stale address
	assign epc_fwd = (wcp0 && waddr == cp0_reg_pkg::CP0_EPC) ? wdata : epc;

	always_comb
	begin
		if (!rst_n)
		begin
			exc_en = 1'b0;
			pc_exc = '0;
		end
		else if (trap_take)
		begin
			exc_en = 1'b1;
			if (exc_code == cp0_exc_pkg::EXC_ERET)
				pc_exc = epc_fwd;	// back to victim
			else
				pc_exc = cp0_exc_pkg::EXC_VECTOR;
		end
		else
		begin
			exc_en = 1'b0;
			pc_exc = '0;
		end
	end

endmodule

/* exception/cp0_exc_regs.sv */
`timescale 1ns/100ps
module cp0_exc_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   trap_take,
	input  cp0_exc_pkg::exc_code_t exc_code,
	input  cp0_exc_pkg::hw_irq_t   hw_irq,
	input  logic                   sw_write,
	input  cp0_reg_pkg::cp0_addr_t waddr,
	input  cp0_reg_pkg::cp0_word_t wdata,
	input  cp0_reg_pkg::cp0_word_t victim_pc,
	input  logic                   is_delayslot,
	input  cp0_reg_pkg::cp0_word_t badvaddr,
	output cp0_reg_pkg::cp0_word_t status,
	output cp0_reg_pkg::cp0_word_t cause_reg,
	output cp0_reg_pkg::cp0_word_t epc,
	output cp0_reg_pkg::cp0_word_t badvaddr_reg
);

	cp0_reg_pkg::cp0_word_t trap_epc;
	cp0_reg_pkg::cp0_word_t trap_badvaddr;
	logic                   exl;
	logic                   is_eret;
	logic                   is_addr_err;

	assign exl     = status[cp0_reg_pkg::STATUS_EXL];
	assign is_eret = (exc_code == cp0_exc_pkg::EXC_ERET);
	assign is_addr_err = (exc_code == cp0_exc_pkg::EXC_ADEL) ||
		(exc_code == cp0_exc_pkg::EXC_ADES);

	// restart at the branch when the victim is in its slot
	assign trap_epc = is_delayslot ? (victim_pc - cp0_exc_pkg::DELAY_SLOT_OFFSET) : victim_pc;

	// AdEL covers fetch and load, a bad pc means the fetch failed
	always_comb
	begin
		if (exc_code == cp0_exc_pkg::EXC_ADEL && victim_pc[1:0] != 2'b00)
			trap_badvaddr = victim_pc;
		else
			trap_badvaddr = badvaddr;	// load/store data address
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			status       <= cp0_reg_pkg::STATUS_RESET;
			cause_reg    <= '0;
			epc          <= '0;
			badvaddr_reg <= '0;
		end
		else if (trap_take)
		begin
			if (is_eret)
				status[cp0_reg_pkg::STATUS_EXL] <= 1'b0;	// leave handler
			else
			begin
				cause_reg[cp0_reg_pkg::CAUSE_CODE_HI:cp0_reg_pkg::CAUSE_CODE_LO] <= exc_code;
				cause_reg[cp0_reg_pkg::CAUSE_IP_HW_HI:cp0_reg_pkg::CAUSE_IP_HW_LO] <= hw_irq;
				if (!exl)	// no nesting, keep the first victim
				begin
					status[cp0_reg_pkg::STATUS_EXL] <= 1'b1;
					epc                             <= trap_epc;
					cause_reg[cp0_reg_pkg::CAUSE_BD] <= is_delayslot;
					if (is_addr_err)
						badvaddr_reg <= trap_badvaddr;
				end
			end
		end
		else if (sw_write)
		begin
			case (waddr)
				cp0_reg_pkg::CP0_STATUS:
				begin
					status <= wdata;
				end
				cp0_reg_pkg::CP0_CAUSE:
				begin
					// only IP[1:0], IV and WP are software visible
					cause_reg[cp0_reg_pkg::CAUSE_IP_SW_HI:cp0_reg_pkg::CAUSE_IP_SW_LO] <=
						wdata[cp0_reg_pkg::CAUSE_IP_SW_HI:cp0_reg_pkg::CAUSE_IP_SW_LO];
					cause_reg[cp0_reg_pkg::CAUSE_WR_HI:cp0_reg_pkg::CAUSE_WR_LO] <=
						wdata[cp0_reg_pkg::CAUSE_WR_HI:cp0_reg_pkg::CAUSE_WR_LO];
				end
				cp0_reg_pkg::CP0_EPC:
				begin
					epc <= wdata;
				end
				default:
				begin
					// other numbers belong to the timer or are read only
				end
			endcase
		end
	end

endmodule

/* logic/cp0_timer.sv */
`timescale 1ns/100ps
module cp0_timer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   sw_write,
	input  cp0_reg_pkg::cp0_addr_t waddr,
	input  cp0_reg_pkg::cp0_word_t wdata,
	output cp0_reg_pkg::cp0_word_t count,
	output cp0_reg_pkg::cp0_word_t compare,
	output logic                   timer_int
);

	logic count_wr;
	logic compare_wr;
	logic hit;

	assign count_wr   = sw_write && (waddr == cp0_reg_pkg::CP0_COUNT);
	assign compare_wr = sw_write && (waddr == cp0_reg_pkg::CP0_COMPARE);
	assign hit        = (count == compare) && (count != '0);	// zero never fires

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			count     <= '0;
			compare   <= '0;
			timer_int <= 1'b0;
		end
		else
		begin
			if (count_wr)
				count <= wdata;
			else
				count <= count + 32'd1;	// free running, every cycle

			if (compare_wr)
			begin
				compare   <= wdata;
				timer_int <= 1'b0;	// ack by rewriting compare
			end
			else if (hit)
				timer_int <= 1'b1;	// sticky until acked
		end
	end

endmodule

/* logic/cp0_read_mux.sv */
`timescale 1ns/100ps
module cp0_read_mux (
	input  logic                   rst_n,
	input  logic                   wcp0,
	input  cp0_reg_pkg::cp0_addr_t waddr,
	input  cp0_reg_pkg::cp0_word_t wdata,
	input  cp0_reg_pkg::cp0_addr_t raddr,
	input  logic [4:0]             int_i,
	input  logic                   timer_int,
	input  cp0_reg_pkg::cp0_word_t status,
	input  cp0_reg_pkg::cp0_word_t cause_reg,
	input  cp0_reg_pkg::cp0_word_t epc,
	input  cp0_reg_pkg::cp0_word_t badvaddr_reg,
	input  cp0_reg_pkg::cp0_word_t count,
	input  cp0_reg_pkg::cp0_word_t compare,
	output cp0_reg_pkg::cp0_word_t read_data
);

	cp0_exc_pkg::hw_irq_t live_ip;

	assign live_ip = {timer_int, int_i};	// raw unmasked lines with the timer on top

	always_comb
	begin
		if (!rst_n)
			read_data = '0;
		else if (wcp0 && waddr == raddr)
			read_data = wdata;	// mtc0 then mfc0 back to back
		else
		begin
			case (raddr)
				cp0_reg_pkg::CP0_BADVADDR: read_data = badvaddr_reg;
				cp0_reg_pkg::CP0_COUNT:    read_data = count;
				cp0_reg_pkg::CP0_COMPARE:  read_data = compare;
				cp0_reg_pkg::CP0_STATUS:   read_data = status;
				cp0_reg_pkg::CP0_CAUSE:
					read_data = {cause_reg[31:cp0_reg_pkg::CAUSE_IP_HW_HI + 1], live_ip,
						cause_reg[cp0_reg_pkg::CAUSE_IP_HW_LO - 1:0]};
				cp0_reg_pkg::CP0_EPC:      read_data = epc;
				cp0_reg_pkg::CP0_PRID:     read_data = cp0_reg_pkg::PRID_VALUE;
				default:                   read_data = '0;	// unmapped
			endcase
		end
	end

endmodule

/* logic/cp0_top.sv */
`timescale 1ns/100ps
module cp0_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   wcp0,
	input  cp0_reg_pkg::cp0_addr_t waddr,
	input  cp0_reg_pkg::cp0_word_t wdata,
	input  cp0_reg_pkg::cp0_addr_t raddr,
	input  cp0_exc_pkg::exc_vec_t  exc_type,
	input  logic [4:0]             int_i,
	input  cp0_reg_pkg::cp0_word_t victim_pc,
	input  logic                   is_delayslot,
	input  cp0_reg_pkg::cp0_word_t badvaddr,
	output cp0_reg_pkg::cp0_word_t read_data,
	output logic                   exc_en,
	output cp0_reg_pkg::cp0_word_t pc_exc
);

	logic                   trap_take;	// arbiter -> regs
	cp0_exc_pkg::exc_code_t exc_code;
	cp0_exc_pkg::hw_irq_t   hw_irq;
	logic                   sw_write;	// mtc0 that survived
	cp0_reg_pkg::cp0_word_t status;
	cp0_reg_pkg::cp0_word_t cause_reg;
	cp0_reg_pkg::cp0_word_t epc;
	cp0_reg_pkg::cp0_word_t badvaddr_reg;
	cp0_reg_pkg::cp0_word_t count;
	cp0_reg_pkg::cp0_word_t compare;
	logic                   timer_int;

	cp0_trap_arbiter cp0_trap_arbiter_inst (
		.rst_n     (rst_n),
		.wcp0      (wcp0),
		.waddr     (waddr),
		.wdata     (wdata),
		.exc_type  (exc_type),
		.int_i     (int_i),
		.timer_int (timer_int),
		.status    (status),
		.cause_reg (cause_reg),
		.epc       (epc),
		.exc_en    (exc_en),
		.pc_exc    (pc_exc),
		.trap_take (trap_take),
		.exc_code  (exc_code),
		.hw_irq    (hw_irq),
		.sw_write  (sw_write)
	);

	cp0_exc_regs cp0_exc_regs_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.trap_take    (trap_take),
		.exc_code     (exc_code),
		.hw_irq       (hw_irq),
		.sw_write     (sw_write),
		.waddr        (waddr),
		.wdata        (wdata),
		.victim_pc    (victim_pc),
		.is_delayslot (is_delayslot),
		.badvaddr     (badvaddr),
		.status       (status),
		.cause_reg    (cause_reg),
		.epc          (epc),
		.badvaddr_reg (badvaddr_reg)
	);

	cp0_timer cp0_timer_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.sw_write  (sw_write),
		.waddr     (waddr),
		.wdata     (wdata),
		.count     (count),
		.compare   (compare),
		.timer_int (timer_int)
	);

	cp0_read_mux cp0_read_mux_inst (
		.rst_n        (rst_n),
		.wcp0         (wcp0),
		.waddr        (waddr),
		.wdata        (wdata),
		.raddr        (raddr),
		.int_i        (int_i),
		.timer_int    (timer_int),
		.status       (status),
		.cause_reg    (cause_reg),
		.epc          (epc),
		.badvaddr_reg (badvaddr_reg),
		.count        (count),
		.compare      (compare),
		.read_data    (read_data)
	);

endmodule

/* testbench/tb_cp0_top.sv */
`timescale 1ns/100ps
module tb_cp0_top;

	logic                   clk;
	logic                   rst_n;
	logic                   wcp0;
	cp0_reg_pkg::cp0_addr_t waddr;
	cp0_reg_pkg::cp0_word_t wdata;
	cp0_reg_pkg::cp0_addr_t raddr;
	cp0_exc_pkg::exc_vec_t  exc_type;
	logic [4:0]             int_i;
	cp0_reg_pkg::cp0_word_t victim_pc;
	logic                   is_delayslot;
	cp0_reg_pkg::cp0_word_t badvaddr;
	cp0_reg_pkg::cp0_word_t read_data;
	logic                   exc_en;
	cp0_reg_pkg::cp0_word_t pc_exc;

	integer errors;
	integer checks;
	integer seed;

	cp0_top cp0_top_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.wcp0         (wcp0),
		.waddr        (waddr),
		.wdata        (wdata),
		.raddr        (raddr),
		.exc_type     (exc_type),
		.int_i        (int_i),
		.victim_pc    (victim_pc),
		.is_delayslot (is_delayslot),
		.badvaddr     (badvaddr),
		.read_data    (read_data),
		.exc_en       (exc_en),
		.pc_exc       (pc_exc)
	);

	always #5 clk = ~clk;	// 10 ns period

	function automatic cp0_exc_pkg::exc_vec_t exc_bit(input int pos);
		cp0_exc_pkg::exc_vec_t v;
		v      = '0;
		v[pos] = 1'b1;	// one request line
		return v;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;	// drive just after the edge
	endtask

	task automatic settle();
		#4;	// comb outputs stable mid cycle
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic write_reg(input cp0_reg_pkg::cp0_addr_t addr,
		input cp0_reg_pkg::cp0_word_t data);
		next_cycle();
		wcp0  = 1'b1;	// single cycle mtc0
		waddr = addr;
		wdata = data;
		settle();
		next_cycle();
		wcp0 = 1'b0;
	endtask

	task automatic read_word(input cp0_reg_pkg::cp0_addr_t addr,
		output cp0_reg_pkg::cp0_word_t value);
		next_cycle();
		raddr = addr;
		settle();
		value = read_data;
	endtask

	task automatic read_check(input string name, input cp0_reg_pkg::cp0_addr_t addr,
		input cp0_reg_pkg::cp0_word_t exp);
		cp0_reg_pkg::cp0_word_t value;
		read_word(addr, value);
		compare_value(name, value, exp);
	endtask

	// write and read one number with the bypass first and the stored copy after
	task automatic write_bypass(input string name, input cp0_reg_pkg::cp0_addr_t addr,
		input cp0_reg_pkg::cp0_word_t data);
		next_cycle();
		wcp0  = 1'b1;
		waddr = addr;
		wdata = data;
		raddr = addr;
		settle();
		compare_value({name, " bypass"}, read_data, data);
		next_cycle();
		wcp0 = 1'b0;
		settle();
		compare_value({name, " stored"}, read_data, data);
	endtask

	task automatic take_exception(input cp0_exc_pkg::exc_vec_t vec, input cp0_reg_pkg::cp0_word_t pc,
		input logic ds, input cp0_reg_pkg::cp0_word_t bad, input cp0_exc_pkg::exc_code_t exp_code,
		input cp0_reg_pkg::cp0_word_t exp_epc);
		cp0_reg_pkg::cp0_word_t value;
		next_cycle();
		exc_type     = vec;
		victim_pc    = pc;
		is_delayslot = ds;
		badvaddr     = bad;
		settle();
		compare_value("exc_en", 32'(exc_en), 32'd1);	// redirect in the same cycle
		compare_value("pc_exc", pc_exc, 32'hbfc0_0380);
		next_cycle();
		exc_type     = '0;
		is_delayslot = 1'b0;
		raddr        = cp0_reg_pkg::CP0_CAUSE;
		settle();
		compare_value("Cause.ExcCode", 32'(read_data[6:2]), 32'(exp_code));
		read_check("EPC", cp0_reg_pkg::CP0_EPC, exp_epc);
		read_word(cp0_reg_pkg::CP0_STATUS, value);
		compare_value("Status.EXL after trap", 32'(value[1]), 32'd1);
	endtask

	task automatic return_from_trap(input cp0_reg_pkg::cp0_word_t exp_epc);
		next_cycle();
		exc_type = exc_bit(cp0_exc_pkg::EXV_ERET);
		settle();
		compare_value("exc_en on eret", 32'(exc_en), 32'd1);
		compare_value("pc_exc on eret", pc_exc, exp_epc);	// back to EPC
		next_cycle();
		exc_type = '0;
		raddr    = cp0_reg_pkg::CP0_STATUS;
		settle();
		compare_value("Status.EXL after eret", 32'(read_data[1]), 32'd0);
	endtask

	task automatic test_reset();
		cp0_reg_pkg::cp0_word_t first;
		cp0_reg_pkg::cp0_word_t second;
		exc_type = exc_bit(cp0_exc_pkg::EXV_SYS);	// must stay hidden in reset
		raddr    = cp0_reg_pkg::CP0_PRID;
		repeat (8)
		begin
			next_cycle();
			settle();
			compare_value("exc_en in reset", 32'(exc_en), 32'd0);
			compare_value("pc_exc in reset", pc_exc, 32'd0);
			compare_value("read_data in reset", read_data, 32'd0);
		end
		next_cycle();
		exc_type = '0;
		rst_n    = 1'b1;
		read_check("Status after reset", cp0_reg_pkg::CP0_STATUS, 32'h1000_0000);
		read_check("PRId", cp0_reg_pkg::CP0_PRID, 32'h0057_0102);
		read_word(cp0_reg_pkg::CP0_COUNT, first);
		repeat (3) next_cycle();
		read_word(cp0_reg_pkg::CP0_COUNT, second);
		checks = checks + 1;
		if (second <= first)
		begin
			errors = errors + 1;
			$display("** Error at %0t ns: Count read %h then %h, expected an increase",
				$time, first, second);
		end
	endtask

	task automatic test_register_access();
		cp0_reg_pkg::cp0_word_t epc_val;
		cp0_reg_pkg::cp0_word_t cmp_val;
		epc_val = $random(seed);
		cmp_val = $random(seed) | 32'h8000_0000;	// far above Count
		write_bypass("EPC", cp0_reg_pkg::CP0_EPC, epc_val);
		write_bypass("Compare", cp0_reg_pkg::CP0_COMPARE, cmp_val);
		write_reg(cp0_reg_pkg::CP0_CAUSE, 32'hffff_ffff);
		read_check("Cause after all-ones write", cp0_reg_pkg::CP0_CAUSE, 32'h00c0_0300);
		write_reg(cp0_reg_pkg::CP0_CAUSE, 32'h0000_0000);
	endtask

	task automatic test_exceptions();
		cp0_reg_pkg::cp0_word_t value;
		// misaligned fetch so BadVAddr takes the pc and not the data address
		take_exception(exc_bit(cp0_exc_pkg::EXV_ADEL), 32'h0040_0102, 1'b0, 32'h1234_5678,
			5'd4, 32'h0040_0102);
		read_check("BadVAddr", cp0_reg_pkg::CP0_BADVADDR, 32'h0040_0102);
		return_from_trap(32'h0040_0102);
		take_exception(exc_bit(cp0_exc_pkg::EXV_SYS), 32'h0040_0200, 1'b1, '0,
			5'd8, 32'h0040_01fc);	// delay slot restarts at the branch
		read_word(cp0_reg_pkg::CP0_CAUSE, value);
		compare_value("Cause.BD", 32'(value[31]), 32'd1);
		return_from_trap(32'h0040_01fc);
	endtask

	task automatic test_priority();
		take_exception(exc_bit(cp0_exc_pkg::EXV_SYS) | exc_bit(cp0_exc_pkg::EXV_BP) |
			exc_bit(cp0_exc_pkg::EXV_OV), 32'h0040_0400, 1'b0, '0, 5'd8, 32'h0040_0400);
		return_from_trap(32'h0040_0400);
		take_exception(exc_bit(cp0_exc_pkg::EXV_ADES) | exc_bit(cp0_exc_pkg::EXV_SYS) |
			exc_bit(cp0_exc_pkg::EXV_TR), 32'h0040_0400, 1'b0, '0, 5'd5, 32'h0040_0400);
		return_from_trap(32'h0040_0400);
		take_exception(exc_bit(cp0_exc_pkg::EXV_ADEL) | exc_bit(cp0_exc_pkg::EXV_ADES) |
			exc_bit(cp0_exc_pkg::EXV_SYS), 32'h0040_0400, 1'b0, '0, 5'd4, 32'h0040_0400);
		return_from_trap(32'h0040_0400);
		take_exception(exc_bit(cp0_exc_pkg::EXV_BP) | exc_bit(cp0_exc_pkg::EXV_RI),
			32'h0040_0400, 1'b0, '0, 5'd9, 32'h0040_0400);
		return_from_trap(32'h0040_0400);
		take_exception(exc_bit(cp0_exc_pkg::EXV_RI) | exc_bit(cp0_exc_pkg::EXV_OV),
			32'h0040_0400, 1'b0, '0, 5'd10, 32'h0040_0400);
		return_from_trap(32'h0040_0400);
		take_exception(exc_bit(cp0_exc_pkg::EXV_OV) | exc_bit(cp0_exc_pkg::EXV_TR),
			32'h0040_0400, 1'b0, '0, 5'd12, 32'h0040_0400);
		return_from_trap(32'h0040_0400);
		take_exception(exc_bit(cp0_exc_pkg::EXV_TR) | exc_bit(cp0_exc_pkg::EXV_ERET),
			32'h0040_0400, 1'b0, '0, 5'd13, 32'h0040_0400);	// eret loses to trap
		return_from_trap(32'h0040_0400);
	endtask

	task automatic test_interrupts();
		write_reg(cp0_reg_pkg::CP0_STATUS, 32'h1000_1001);	// IE and IM for int_i[2]
		next_cycle();
		int_i     = 5'b00100;
		victim_pc = 32'h0040_0500;
		settle();
		compare_value("exc_en on int_i", 32'(exc_en), 32'd1);
		compare_value("pc_exc on int_i", pc_exc, 32'hbfc0_0380);
		next_cycle();
		raddr = cp0_reg_pkg::CP0_CAUSE;	// line still high while EXL is set
		settle();
		compare_value("exc_en with EXL set", 32'(exc_en), 32'd0);
		compare_value("Cause.ExcCode for int", 32'(read_data[6:2]), 32'd0);
		compare_value("Cause.IP for int_i[2]", 32'(read_data[12]), 32'd1);
		next_cycle();
		int_i = '0;
		return_from_trap(32'h0040_0500);
		write_reg(cp0_reg_pkg::CP0_STATUS, 32'h1000_0101);	// IE and sw IM0
		next_cycle();
		wcp0      = 1'b1;
		waddr     = cp0_reg_pkg::CP0_CAUSE;
		wdata     = 32'h0000_0100;	// raise sw IP0
		victim_pc = 32'h0040_0600;
		settle();
		compare_value("exc_en during Cause write", 32'(exc_en), 32'd0);
		next_cycle();
		wcp0 = 1'b0;
		settle();
		compare_value("exc_en on sw interrupt", 32'(exc_en), 32'd1);
		compare_value("pc_exc on sw interrupt", pc_exc, 32'hbfc0_0380);
		next_cycle();
		raddr = cp0_reg_pkg::CP0_CAUSE;
		settle();
		compare_value("Cause.ExcCode for sw int", 32'(read_data[6:2]), 32'd0);
		write_reg(cp0_reg_pkg::CP0_CAUSE, 32'h0000_0000);	// drop sw IP before leaving
		return_from_trap(32'h0040_0600);
		write_reg(cp0_reg_pkg::CP0_STATUS, 32'h1000_0000);
	endtask

	task automatic test_timer();
		cp0_reg_pkg::cp0_word_t value;
		integer waited;
		logic seen;
		write_reg(cp0_reg_pkg::CP0_COUNT, 32'h0000_0100);
		write_reg(cp0_reg_pkg::CP0_COMPARE, 32'h0000_0140);
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < 200)	// timer sits in Cause bit 15
		begin
			next_cycle();
			raddr = cp0_reg_pkg::CP0_CAUSE;
			settle();
			seen   = read_data[15];
			waited = waited + 1;
		end
		checks = checks + 1;
		if (!seen)
		begin
			errors = errors + 1;
			$display("timeout: timer interrupt never showed in Cause within 200 cycles");
		end
		write_reg(cp0_reg_pkg::CP0_COMPARE, 32'h0010_0000);	// ack
		read_word(cp0_reg_pkg::CP0_CAUSE, value);
		compare_value("Cause timer bit after Compare write", 32'(value[15]), 32'd0);
	endtask

	initial
	begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		wcp0         = 1'b0;
		waddr        = '0;
		wdata        = '0;
		raddr        = '0;
		exc_type     = '0;
		int_i        = '0;
		victim_pc    = '0;
		is_delayslot = 1'b0;
		badvaddr     = '0;
		errors       = 0;
		checks       = 0;
		seed         = 98638;
		test_reset();
		test_register_access();
		test_exceptions();
		test_priority();
		test_interrupts();
		test_timer();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* project.f */
common/cp0_reg_pkg.sv
common/cp0_exc_pkg.sv
exception/cp0_trap_arbiter.sv
exception/cp0_exc_regs.sv
logic/cp0_timer.sv
logic/cp0_read_mux.sv
logic/cp0_top.sv
testbench/tb_cp0_top.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timescale 1ns/100ps --top-module tb_cp0_top -f project.f -o tb_cp0_top
	./obj_dir/tb_cp0_top | tee sim.log
	grep -q "^\*\* PASS \*\*$$" sim.log

clean:
	rm -rf obj_dir sim.log
